// ==== build.f ====
+incdir+logic
logic/scroll_pkg.sv
logic/scroll_regs.sv
logic/scroll_map_addr.sv
logic/scroll_tile_fetch.sv
logic/scroll_palette.sv
logic/scroll_layer.sv
dv/scroll_layer_sva.sv
dv/scroll_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide by the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module scroll_tb -f build.f -o scroll_sim || exit 1
out=$(./obj_dir/scroll_sim)
echo "$out"
echo "$out" | grep -qx "No errors" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== dv/scroll_tb.sv ====
`default_nettype none

`include "scroll_params.svh"

module scroll_tb;
    import scroll_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int RESET_CYC   = 10;
    localparam int BUS_OPS     = 700;   // Upper bound over all tests
    localparam int PIX_TICKS   = 600;   // Per pixel test, four of them
    localparam int GAP_TICKS   = 400;   // Up to 3 idle cycles each
    localparam int TEST_CYCLES = RESET_CYC + BUS_OPS * 6 + 4 * PIX_TICKS + 4 * GAP_TICKS;

    logic                   clk;
    logic                   reset;
    logic                   cen6;
    logic [`SCR_H_W-1:0]    h;
    logic [`SCR_V_W-1:0]    v;
    wb_req_t                wb_req;
    wb_rsp_t                wb_rsp;
    logic [`SCR_MAP_AW-1:0] map_addr;
    logic [15:0]            map_data;
    logic [`SCR_GFX_AW-1:0] gfx_addr;
    logic [15:0]            gfx_data;
    logic [`SCR_PXL_W-1:0]  pxl;

    logic [15:0] map_rom [1 << `SCR_MAP_AW];
    logic [15:0] gfx_rom [1 << `SCR_GFX_AW];
    logic [7:0]  sh_pal [256];         // Mirror of palette RAM
    scroll_cfg_t sh_cfg;               // Mirror of scroll registers
    logic [31:0] lfsr = 32'd90;
    logic [7:0]  exp_q [$];            // Expected pixels in flight
    logic        prev_en;              // What the DUT samples at the coming edge
    logic [`SCR_H_W-1:0] prev_h;
    logic [`SCR_V_W-1:0] prev_v;
    logic [7:0]  last_pxl;
    logic [7:0]  attr_one;             // Attribute bits seen high
    logic [7:0]  attr_zero;            // and seen low
    logic [31:0] r;

    scroll_layer u_scroll_layer (
        .clk      (clk),
        .reset    (reset),
        .cen6     (cen6),
        .h        (h),
        .v        (v),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .map_addr (map_addr),
        .map_data (map_data),
        .gfx_addr (gfx_addr),
        .gfx_data (gfx_data),
        .pxl      (pxl)
    );

    // ROMs answer in the same cycle
    assign map_data = map_rom[map_addr];
    assign gfx_data = gfx_rom[gfx_addr];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp));
        end
    endtask

    // Reference pixel path
    function automatic logic [15:0] scroll_x(input logic [8:0] hb);
        logic [8:0] hf;
        hf = sh_cfg.flip ? ~hb : hb;  // Screen flip
        return sh_cfg.hpos + {7'd0, hf};
    endfunction

    function automatic logic [7:0] scroll_y(input logic [7:0] vb);
        logic [7:0] vf;
        vf = sh_cfg.flip ? ~vb : vb;
        return sh_cfg.vpos + vf;      // Wraps at 256
    endfunction

    function automatic logic [15:0] map_word(input logic [15:0] x, input logic [7:0] y);
        return map_rom[{x[15:8], x[7:6], y[7:5], x[5]}];
    endfunction

    function automatic logic [7:0] ref_pixel(input logic [15:0] x, input logic [7:0] y);
        logic [15:0] mw;
        logic [4:0]  col;
        logic [4:0]  row;
        logic [15:0] gw;
        logic [3:0]  nib;
        mw  = map_word(x, y);
        col = mw[15] ? ~x[4:0] : x[4:0];  // Tile hflip
        row = mw[14] ? ~y[4:0] : y[4:0];  // Tile vflip
        gw  = gfx_rom[{mw[8], mw[7:0], row, col[4:2]}];
        nib = gw[{col[1:0], 2'b00} +: 4];
        return sh_cfg.enable ? sh_pal[{mw[13:10], nib}] : 8'd0;
    endfunction

    // One clock; checks the edge that consumed the previous drive
    task automatic step(input logic en);
        logic [31:0] rnd;
        logic [15:0] x;
        logic [7:0]  y;
        logic [15:0] mw;
        take_bits(17, rnd);
        @(posedge clk);
        cen6 <= en;
        h    <= rnd[16:8];
        v    <= rnd[7:0];
        @(negedge clk);
        if (prev_en) begin
            x  = scroll_x(prev_h);
            y  = scroll_y(prev_v);
            mw = map_word(x, y);
            attr_one  = attr_one | mw[15:8];
            attr_zero = attr_zero | ~mw[15:8];
            exp_q.push_back(ref_pixel(x, y));
            if (exp_q.size() == `SCR_LAT) check_value(32'(pxl), 32'(exp_q.pop_front()), "pxl");
        end else begin
            check_value(32'(pxl), 32'(last_pxl), "pxl while cen6 low");
        end
        last_pxl = pxl;
        prev_en  = en;
        prev_h   = rnd[16:8];
        prev_v   = rnd[7:0];
    endtask

    task automatic bus_xfer(input logic we, input logic [8:0] adr, input logic [7:0] dat,
                            output logic [7:0] rdat);
        int waited;
        if (prev_en) step(1'b0);  // Freeze the pixel pipe first
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_rsp.ack && waited < 4);
        if (!wb_rsp.ack) fail_run("Bus transfer got no ack within 4 cycles");
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;             // Drop stb before the next transfer
    endtask

    task automatic write_bus(input logic [8:0] adr, input logic [7:0] dat);
        logic [7:0] rd;
        bus_xfer(1'b1, adr, dat, rd);
    endtask

    task automatic read_check(input logic [8:0] adr, input logic [7:0] exp, input string what);
        logic [7:0] rd;
        bus_xfer(1'b0, adr, 8'd0, rd);
        check_value(32'(rd), 32'(exp), what);
    endtask

    task automatic set_cfg(input logic [15:0] hpos, input logic [7:0] vpos,
                           input logic en, input logic flip);
        write_bus(9'(HPOS_LO), hpos[7:0]);
        write_bus(9'(HPOS_HI), hpos[15:8]);
        write_bus(9'(VPOS), vpos);
        write_bus(9'(CTRL), {6'd0, flip, en});
        sh_cfg = '{hpos: hpos, vpos: vpos, enable: en, flip: flip};
    endtask

    task automatic random_cfg(input logic en, input logic flip);
        logic [31:0] rnd;
        take_bits(24, rnd);
        set_cfg(rnd[23:8], rnd[7:0], en, flip);
    endtask

    task automatic run_pixels(input int ticks);
        exp_q.delete();           // Older pixels are flushed by the new ones
        repeat (ticks) step(1'b1);
    endtask

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD + 2000);
        fail_run("Watchdog expired before the tests finished");
    end

    initial begin
        reset   <= 1'b1;
        cen6    <= 1'b0;
        h       <= '0;
        v       <= '0;
        wb_req  <= '0;
        sh_cfg   = '0;
        prev_en  = 1'b0;
        prev_h   = '0;
        prev_v   = '0;
        last_pxl = '0;
        attr_one  = '0;
        attr_zero = '0;
        for (int a = 0; a < (1 << `SCR_MAP_AW); a++) begin
            take_bits(16, r);
            map_rom[a] = r[15:0];
        end
        for (int a = 0; a < (1 << `SCR_GFX_AW); a++) begin
            take_bits(16, r);
            gfx_rom[a] = r[15:0];
        end
        repeat (RESET_CYC) @(posedge clk);
        reset <= 1'b0;

        // Palette load, all 256 entries
        for (int i = 0; i < 256; i++) begin
            take_bits(8, r);
            write_bus({1'b1, 8'(i)}, r[7:0]);
            sh_pal[i] = r[7:0];
        end

        // Register write and readback
        for (int i = 0; i < 8; i++) begin
            take_bits(26, r);
            set_cfg(r[15:0], r[23:16], r[24], r[25]);
            read_check(9'(HPOS_LO), sh_cfg.hpos[7:0], "HPOS_LO readback");
            read_check(9'(HPOS_HI), sh_cfg.hpos[15:8], "HPOS_HI readback");
            read_check(9'(VPOS), sh_cfg.vpos, "VPOS readback");
            read_check(9'(CTRL), {6'd0, sh_cfg.flip, sh_cfg.enable}, "CTRL readback");
        end
        for (int i = 0; i < 8; i++) begin
            take_bits(8, r);
            read_check({1'b0, r[7:0] | 8'h04}, 8'd0, "unused register read");
            read_check({1'b1, r[7:0]}, 8'd0, "palette range read");
        end

        random_cfg(1'b1, 1'b0);   // Plain scroll
        run_pixels(PIX_TICKS);
        random_cfg(1'b1, 1'b1);   // Screen flip
        run_pixels(PIX_TICKS);

        // Tile attributes both ways
        attr_one  = '0;
        attr_zero = '0;
        take_bits(1, r);
        random_cfg(1'b1, r[0]);
        run_pixels(PIX_TICKS);
        check_value(32'(attr_one & attr_zero & 8'hFD), 32'h0000_00FD, "tile attribute coverage");

        take_bits(1, r);
        random_cfg(1'b0, r[0]);   // Layer off, all pixels blank
        run_pixels(PIX_TICKS);

        // Random cen6 gaps, scroll moves while frozen
        random_cfg(1'b1, 1'b0);
        exp_q.delete();
        for (int i = 0; i < GAP_TICKS; i++) begin
            take_bits(2, r);
            repeat (r[1:0]) step(1'b0);
            step(1'b1);
            if (i % 50 == 49) begin
                take_bits(1, r);
                random_cfg(1'b1, r[0]);
            end
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/scroll_layer_sva.sv ====
`default_nettype none

`include "scroll_params.svh"

module scroll_layer_sva (
    input wire                      clk,
    input wire                      reset,
    input wire                      cen6,
    input wire scroll_pkg::wb_req_t wb_req,
    input wire scroll_pkg::wb_rsp_t wb_rsp,
    input wire [`SCR_MAP_AW-1:0]    map_addr,
    input wire [`SCR_PXL_W-1:0]     pxl
);

    // Ack only answers a sampled request
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack rose without cyc and stb");

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack held longer than one cycle");

    // Pipe frozen between pixel ticks
    hold_on_idle: assert property (@(posedge clk) disable iff (reset)
        !cen6 |=> ($stable(pxl) && $stable(map_addr)))
        else $error("pxl or map_addr moved with cen6 low");

    ack_low_after_reset: assert property (@(posedge clk)
        reset |=> !wb_rsp.ack)
        else $error("ack high after reset");

endmodule

bind scroll_layer scroll_layer_sva u_sva (
    .clk      (clk),
    .reset    (reset),
    .cen6     (cen6),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .map_addr (map_addr),
    .pxl      (pxl)
);

`default_nettype wire

// ==== logic/scroll_layer.sv ====
`default_nettype none

`include "scroll_params.svh"

module scroll_layer (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       cen6,       // 6 MHz pixel enable
    input  wire [`SCR_H_W-1:0]        h,
    input  wire [`SCR_V_W-1:0]        v,
    input  wire scroll_pkg::wb_req_t  wb_req,
    output scroll_pkg::wb_rsp_t       wb_rsp,
    output logic [`SCR_MAP_AW-1:0]    map_addr,   // To map ROM
    input  wire [15:0]                map_data,
    output logic [`SCR_GFX_AW-1:0]    gfx_addr,   // To gfx ROM
    input  wire [15:0]                gfx_data,
    output logic [`SCR_PXL_W-1:0]     pxl
);
    import scroll_pkg::*;

    scroll_cfg_t cfg;
    pal_wr_t     pal_wr;
    tile_pos_t   pos;       // Map stage to fetch stage
    logic [3:0]  pal_sel;
    logic [3:0]  colour;
    logic        enable;

    // Bus registers
    scroll_regs u_regs (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .cfg    (cfg),
        .pal_wr (pal_wr)
    );

    scroll_map_addr u_map_addr (
        .clk      (clk),
        .reset    (reset),
        .cen6     (cen6),
        .h        (h),
        .v        (v),
        .cfg      (cfg),
        .map_addr (map_addr),
        .pos      (pos)
    );

    scroll_tile_fetch u_tile_fetch (
        .clk      (clk),
        .reset    (reset),
        .cen6     (cen6),
        .pos      (pos),
        .map_data (map_data),
        .gfx_data (gfx_data),
        .gfx_addr (gfx_addr),
        .pal_sel  (pal_sel),
        .colour   (colour),
        .enable   (enable)
    );

    // Colour lookup and output register
    scroll_palette u_palette (
        .clk     (clk),
        .reset   (reset),
        .cen6    (cen6),
        .pal_wr  (pal_wr),
        .colour  (colour),
        .pal_sel (pal_sel),
        .enable  (enable),
        .pxl     (pxl)
    );

endmodule

`default_nettype wire

// ==== logic/scroll_palette.sv ====
`default_nettype none

`include "scroll_params.svh"

module scroll_palette (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     cen6,
    input  wire scroll_pkg::pal_wr_t pal_wr,
    input  wire [3:0]               colour,   // Tile colour group
    input  wire [3:0]               pal_sel,  // Pixel value
    input  wire                     enable,
    output logic [`SCR_PXL_W-1:0]   pxl
);
    import scroll_pkg::*;

    logic [`SCR_PXL_W-1:0] mem [256];  // Sixteen groups of sixteen

    // Bus side write, runs regardless of cen6
    always_ff @(posedge clk) begin
        if (pal_wr.we) mem[pal_wr.idx] <= pal_wr.colour;
    end

    // Stage 3 of 3, blank when the layer is off
    always_ff @(posedge clk) begin
        if (reset) begin
            pxl <= '0;
        end else if (cen6) begin
            pxl <= enable ? mem[{colour, pal_sel}] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/scroll_tile_fetch.sv ====
`default_nettype none

`include "scroll_params.svh"

module scroll_tile_fetch (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       cen6,
    input  wire scroll_pkg::tile_pos_t pos,
    input  wire [15:0]                map_data,  // Map ROM word, same cycle
    input  wire [15:0]                gfx_data,  // Gfx ROM word, same cycle
    output logic [`SCR_GFX_AW-1:0]    gfx_addr,
    output logic [3:0]                pal_sel,
    output logic [3:0]                colour,
    output logic                      enable
);
    import scroll_pkg::*;

    tile_attr_t attr;
    logic [7:0] id;         // Tile number
    logic [4:0] row_f;      // Row after tile vflip
    logic [4:0] col_f;      // Column after tile hflip
    logic [1:0] nib_sel;    // Pixel within gfx word

    assign id   = map_data[7:0];
    assign attr = tile_attr_t'(map_data[15:8]);

    assign row_f = pos.row ^ {5{attr.vflip}};
    assign col_f = pos.col ^ {5{attr.hflip}};

    // Stage 2 of 3
    always_ff @(posedge clk) begin
        if (reset) begin
            gfx_addr <= '0;
            nib_sel  <= '0;
            colour   <= '0;
            enable   <= 1'b0;
        end else if (cen6) begin
            // Eight words per tile row, four pixels per word
            gfx_addr <= {attr.bank, id, row_f, col_f[4:2]};
            nib_sel  <= col_f[1:0];
            colour   <= attr.colour;
            enable   <= pos.enable;
        end
    end

    // Nibble 0 sits in the low bits
    always_comb begin
        case (nib_sel)
            2'd0:    pal_sel = gfx_data[3:0];
            2'd1:    pal_sel = gfx_data[7:4];
            2'd2:    pal_sel = gfx_data[11:8];
            default: pal_sel = gfx_data[15:12];
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/scroll_map_addr.sv ====
`default_nettype none

`include "scroll_params.svh"

module scroll_map_addr (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         cen6,       // Pixel tick
    input  wire [`SCR_H_W-1:0]          h,
    input  wire [`SCR_V_W-1:0]          v,
    input  wire scroll_pkg::scroll_cfg_t cfg,
    output logic [`SCR_MAP_AW-1:0]      map_addr,
    output scroll_pkg::tile_pos_t       pos
);
    import scroll_pkg::*;

    logic [`SCR_H_W-1:0]    hf;     // Beam after screen flip
    logic [`SCR_V_W-1:0]    vf;
    logic [`SCR_HPOS_W-1:0] sx;     // Scrolled x
    logic [`SCR_VPOS_W-1:0] sy;     // Scrolled y, wraps at 256

    // Flip inverts every counter bit
    assign hf = h ^ {`SCR_H_W{cfg.flip}};
    assign vf = v ^ {`SCR_V_W{cfg.flip}};

    // Horizontal sum is zero extended
    assign sx = cfg.hpos + {{(`SCR_HPOS_W - `SCR_H_W){1'b0}}, hf};
    assign sy = cfg.vpos + vf;

    // Stage 1 of 3
    always_ff @(posedge clk) begin
        if (reset) begin
            map_addr <= '0;
            pos      <= '0;
        end else if (cen6) begin
            // Column pair in the LSB keeps neighbouring tiles close
            map_addr   <= {sx[15:8], sx[7:6], sy[7:5], sx[5]};
            pos.col    <= sx[4:0];     // Pixel within tile
            pos.row    <= sy[4:0];
            pos.enable <= cfg.enable;  // Travels with the pixel
        end
    end

endmodule

`default_nettype wire

// ==== logic/scroll_regs.sv ====
`default_nettype none

`include "scroll_params.svh"

module scroll_regs (
    input  wire                     clk,
    input  wire                     reset,
    input  wire scroll_pkg::wb_req_t wb_req,
    output scroll_pkg::wb_rsp_t     wb_rsp,
    output scroll_pkg::scroll_cfg_t cfg,
    output scroll_pkg::pal_wr_t     pal_wr
);
    import scroll_pkg::*;

    logic       req;        // Cycle and strobe both up
    logic       accept;     // Request sampled this edge
    logic       done;       // Acked, waiting for stb to drop
    logic       ack;
    logic       pal_range;
    reg_addr_e  reg_sel;
    logic [7:0] rd_mux;
    logic [7:0] rd_dat;
    logic       pal_we;
    logic [7:0] pal_idx;
    logic [7:0] pal_colour;

    assign req       = wb_req.cyc & wb_req.stb;
    assign accept    = req & ~ack & ~done;  // One ack per strobe
    assign pal_range = wb_req.adr[`SCR_PAL_SEL];
    assign reg_sel   = reg_addr_e'(wb_req.adr[7:0]);

    // Read mux, palette and holes give zero
    always_comb begin
        rd_mux = '0;
        if (!pal_range) begin
            case (reg_sel)
                HPOS_LO: rd_mux = cfg.hpos[7:0];
                HPOS_HI: rd_mux = cfg.hpos[15:8];
                VPOS:    rd_mux = cfg.vpos;
                CTRL:    rd_mux = {6'd0, cfg.flip, cfg.enable};
                default: rd_mux = '0;
            endcase
        end
    end

    // Handshake and register file
    always_ff @(posedge clk) begin
        if (reset) begin
            ack    <= 1'b0;
            done   <= 1'b0;
            pal_we <= 1'b0;
            cfg    <= '0;   // Layer off
        end else begin
            ack    <= accept;
            done   <= req & (ack | done);  // Clears once stb falls
            pal_we <= accept & wb_req.we & pal_range;
            if (accept && wb_req.we && !pal_range) begin
                case (reg_sel)
                    HPOS_LO: cfg.hpos[7:0]  <= wb_req.dat;
                    HPOS_HI: cfg.hpos[15:8] <= wb_req.dat;
                    VPOS:    cfg.vpos       <= wb_req.dat;
                    CTRL: begin
                        cfg.enable <= wb_req.dat[0];
                        cfg.flip   <= wb_req.dat[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Data held alongside ack
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_dat     <= rd_mux;
            pal_idx    <= wb_req.adr[7:0];
            pal_colour <= wb_req.dat;
        end
    end

    assign wb_rsp = '{ack: ack, dat: rd_dat};
    assign pal_wr = '{we: pal_we, idx: pal_idx, colour: pal_colour};

endmodule

`default_nettype wire

// ==== logic/scroll_pkg.sv ====
`default_nettype none

`include "scroll_params.svh"

package scroll_pkg;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`SCR_WB_AW-1:0] adr; // Word address
        logic [7:0]            dat;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    // Live layer configuration
    typedef struct packed {
        logic [`SCR_HPOS_W-1:0] hpos;
        logic [`SCR_VPOS_W-1:0] vpos;
        logic                   enable;
        logic                   flip;   // Whole screen flip
    } scroll_cfg_t;

    // One palette write
    typedef struct packed {
        logic       we;
        logic [7:0] idx;
        logic [7:0] colour;
    } pal_wr_t;

    // High byte of a map word
    typedef struct packed {
        logic       hflip;
        logic       vflip;
        logic [3:0] colour;
        logic       spare;  // Not used by this layer
        logic       bank;   // Top gfx address bit
    } tile_attr_t;

    // Point inside a 32x32 tile
    typedef struct packed {
        logic [4:0] col;
        logic [4:0] row;
        logic       enable;
    } tile_pos_t;

    // Register word addresses, low half of the bus map
    typedef enum logic [7:0] {
        HPOS_LO = 8'h00,
        HPOS_HI = 8'h01,
        VPOS    = 8'h02,
        CTRL    = 8'h03  // Bit 0 enable, bit 1 flip
    } reg_addr_e;

endpackage

`default_nettype wire

// ==== logic/scroll_params.svh ====
`ifndef SCROLL_PARAMS_SVH
`define SCROLL_PARAMS_SVH

// Scroll offsets and beam counters
`define SCR_HPOS_W 16
`define SCR_VPOS_W 8
`define SCR_H_W    9
`define SCR_V_W    8

// External ROM buses and pixel out
`define SCR_MAP_AW 14
`define SCR_GFX_AW 17
`define SCR_PXL_W  8

// Bus word address, bit 8 high selects the palette half
`define SCR_WB_AW   9
`define SCR_PAL_SEL 8

// cen6 ticks from beam position in to pixel out
`define SCR_LAT 3

`endif
